/* design/espm_pkg.sv */
`default_nettype none

package espm_pkg;

    // ------------------------------
    // field types
    // ------------------------------
    typedef logic [31:0] word_t;        // bus and frame data
    typedef logic [5:0]  frame_addr_t;  // word index within a frame
    typedef logic [15:0] reg_addr_t;
    typedef logic [23:0] enc_t;
    typedef logic [15:0] mv_t;

    localparam int FRAME_WORDS = 64;

    // address spaces, upper nibble of reg_addr_t
    localparam logic [3:0] ADDR_MAIN           = 4'h0;
    localparam logic [3:0] ADDR_BOARD_SPECIFIC = 4'hB;

    // main space offsets
    localparam logic [3:0] OFF_POT_DATA = 4'h0;
    localparam logic [3:0] OFF_ENC_LOAD = 4'h4;
    localparam logic [3:0] OFF_ENC_DATA = 4'h5;

    // ------------------------------
    // frame layout
    // ------------------------------
    localparam logic [2:0] GROUP_POS = 3'd1;  // frame addr bits 5..3
    localparam logic [2:0] GROUP_POT = 3'd2;

    localparam frame_addr_t MISC_ADDR_SWITCH = 6'h00;
    localparam frame_addr_t MISC_ADDR_ESII   = 6'h18;
    localparam frame_addr_t MISC_ADDR_ADC    = 6'h20;
    localparam frame_addr_t MISC_ADDR_MODEL  = 6'h28;
    localparam frame_addr_t MISC_ADDR_ID     = 6'h30;

    localparam enc_t  ENC_MIDRANGE = 24'h800000;
    localparam word_t READ_DEFAULT = 32'h0000cccc;

endpackage

`default_nettype wire

/* design/frame_copy_if.sv */
`timescale 1ns/1ps
`default_nettype none

// committed frame, one word per cycle while valid
interface frame_copy_if;
    import espm_pkg::*;

    logic        valid;
    frame_addr_t addr;
    word_t       data;
    logic        frame_done;  // last word of the frame

    modport source (
        output valid, addr, data, frame_done
    );

    modport sink (
        input valid, addr, data, frame_done
    );
endinterface

`default_nettype wire

/* design/espm_frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module espm_frame_buffer (
    input  logic                  sysclk,
    input  logic                  reset,
    input  logic                  rx_word_valid,
    input  espm_pkg::frame_addr_t rx_word_addr,
    input  espm_pkg::word_t       rx_word_data,
    input  logic                  rx_crc_good,
    frame_copy_if.source          copy
);
    import espm_pkg::*;

    word_t       pre_crc_mem [0:FRAME_WORDS-1];
    logic        copy_state;   // 1 while streaming the frame out
    frame_addr_t copy_raddr;
    logic        last_word;

    assign last_word = (copy_raddr == frame_addr_t'(FRAME_WORDS - 1));

    // ------------------------------
    // pre-check buffer
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (rx_word_valid) begin
            pre_crc_mem[rx_word_addr] <= rx_word_data;
        end
    end

    // ------------------------------
    // copy on crc good
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            copy_state      <= 1'b0;
            copy_raddr      <= '0;
            copy.valid      <= 1'b0;
            copy.frame_done <= 1'b0;
        end else begin
            copy.valid      <= copy_state;
            copy.frame_done <= copy_state && last_word;
            if (!copy_state) begin
                if (rx_crc_good) begin  // ignored while a copy runs
                    copy_state <= 1'b1;
                    copy_raddr <= '0;
                end
            end else begin
                copy_raddr <= copy_raddr + 1'b1;  // wraps to 0 after 63
                if (last_word) begin
                    copy_state <= 1'b0;
                end
            end
        end
    end

    // word payload, follows copy_state by one cycle
    always_ff @(posedge sysclk) begin
        copy.addr <= copy_raddr;
        copy.data <= pre_crc_mem[copy_raddr];
    end

endmodule

`default_nettype wire

/* design/espm_field_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module espm_field_decoder (
    input  logic                sysclk,
    input  logic                reset,
    frame_copy_if.sink          copy,
    input  espm_pkg::reg_addr_t fld_raddr,
    output espm_pkg::word_t     pos_value,
    output espm_pkg::word_t     pot_value,
    output espm_pkg::word_t     misc_word [1:5]
);
    import espm_pkg::*;

    word_t      pos [1:7];
    word_t      pot [1:7];
    logic [2:0] word_idx;   // channel within a group
    logic [2:0] sel_chan;
    logic       sel_ok;

    assign word_idx = copy.addr[2:0];

    always_ff @(posedge sysclk) begin
        if (reset) begin
            for (int i = 1; i <= 7; i++) begin
                pos[i] <= '0;
                pot[i] <= '0;
            end
            for (int i = 1; i <= 5; i++) begin
                misc_word[i] <= '0;
            end
        end else if (copy.valid) begin
            if (word_idx != 3'd0) begin
                case (copy.addr[5:3])
                    GROUP_POS: pos[word_idx] <= copy.data;
                    GROUP_POT: pot[word_idx] <= copy.data;
                    default: ;
                endcase
            end else begin
                case (copy.addr)
                    MISC_ADDR_SWITCH: misc_word[1] <= copy.data;
                    MISC_ADDR_ESII:   misc_word[2] <= copy.data;  // esii status
                    MISC_ADDR_ADC:    misc_word[3] <= copy.data;
                    MISC_ADDR_MODEL:  misc_word[4] <= copy.data;  // instrument model
                    MISC_ADDR_ID:     misc_word[5] <= copy.data;
                    default: ;
                endcase
            end
        end
    end

    // channel select from address bits 7..4, only 1 to 7 exist
    assign sel_chan  = fld_raddr[6:4];
    assign sel_ok    = !fld_raddr[7] && (sel_chan != 3'd0);
    assign pos_value = sel_ok ? pos[sel_chan] : '0;
    assign pot_value = sel_ok ? pot[sel_chan] : '0;

endmodule

`default_nettype wire

/* design/link_health_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module link_health_monitor #(
    parameter int WDOG_WINDOW  = 1024,
    parameter int MV_NOMINAL   = 36570,
    parameter int MV_TOLERANCE = 3657
) (
    input  logic            sysclk,
    input  logic            reset,
    input  logic            rx_eof,
    input  logic            rx_crc_good,
    frame_copy_if.sink      copy,
    input  logic            mv_valid,
    input  espm_pkg::mv_t   mv_sample,
    output espm_pkg::word_t crc_good_count,
    output espm_pkg::word_t crc_err_count,
    output espm_pkg::mv_t   mv,
    output logic            mv_good,
    output logic            espm_comm_good
);
    import espm_pkg::*;

    localparam int WDOG_BITS = $clog2(WDOG_WINDOW);
    localparam int MV_MIN    = MV_NOMINAL - MV_TOLERANCE;
    localparam int MV_MAX    = MV_NOMINAL + MV_TOLERANCE;

    logic [WDOG_BITS-1:0] wdog_timer;
    logic                 frame_seen;  // committed frame in this window
    logic                 frame_end;

    assign frame_end = copy.valid && copy.frame_done;

    // ------------------------------
    // crc counters and watchdog
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            crc_good_count <= '0;
            crc_err_count  <= '0;
            wdog_timer     <= '0;
            frame_seen     <= 1'b0;
            espm_comm_good <= 1'b0;
            mv             <= '0;
        end else begin
            if (rx_crc_good) begin
                crc_good_count <= crc_good_count + 1'b1;
            end
            if (rx_eof && !rx_crc_good) begin
                crc_err_count <= crc_err_count + 1'b1;
            end
            if (wdog_timer == WDOG_BITS'(WDOG_WINDOW - 1)) begin  // window end
                wdog_timer     <= '0;
                espm_comm_good <= frame_seen || frame_end;
                frame_seen     <= 1'b0;
            end else begin
                wdog_timer <= wdog_timer + 1'b1;
                if (frame_end) begin
                    frame_seen <= 1'b1;
                end
            end
            if (mv_valid) begin
                mv <= mv_sample;
            end
        end
    end

    // strict window around nominal
    assign mv_good = (32'(mv) > MV_MIN) && (32'(mv) < MV_MAX);

endmodule

`default_nettype wire

/* design/encoder_preload.sv */
`timescale 1ns/1ps
`default_nettype none

module encoder_preload (
    input  logic                sysclk,
    input  logic                reset,
    input  espm_pkg::reg_addr_t reg_waddr,
    input  espm_pkg::word_t     reg_wdata,
    input  logic                reg_wen,
    input  espm_pkg::word_t     pos_value,
    input  espm_pkg::reg_addr_t reg_raddr,
    output espm_pkg::enc_t      enc_load,
    output espm_pkg::enc_t      enc_data
);
    import espm_pkg::*;

    enc_t       preload [1:7];
    enc_t       offset  [1:7];  // preload minus position at write time
    logic [2:0] wr_chan;
    logic [2:0] rd_chan;
    logic       wr_hit;
    logic       rd_ok;

    assign wr_chan = reg_waddr[6:4];
    assign wr_hit  = reg_wen && (reg_waddr[15:12] == ADDR_MAIN)
                     && (reg_waddr[3:0] == OFF_ENC_LOAD)
                     && !reg_waddr[7] && (wr_chan != 3'd0);

    always_ff @(posedge sysclk) begin
        if (reset) begin
            for (int i = 1; i <= 7; i++) begin
                preload[i] <= ENC_MIDRANGE;
                offset[i]  <= ENC_MIDRANGE;
            end
        end else if (wr_hit) begin
            preload[wr_chan] <= reg_wdata[23:0];
            offset[wr_chan]  <= reg_wdata[23:0] - pos_value[23:0];  // mod 2^24
        end
    end

    assign rd_chan  = reg_raddr[6:4];
    assign rd_ok    = !reg_raddr[7] && (rd_chan != 3'd0);
    assign enc_load = rd_ok ? preload[rd_chan] : '0;
    assign enc_data = rd_ok ? pos_value[23:0] + offset[rd_chan] : '0;

endmodule

`default_nettype wire

/* design/board_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module board_regs #(
    parameter espm_pkg::word_t BUILD_NUMBER = 32'h04400000
) (
    input  logic                sysclk,
    input  logic                reset,
    input  espm_pkg::reg_addr_t reg_raddr,
    input  espm_pkg::reg_addr_t reg_waddr,
    input  espm_pkg::word_t     reg_wdata,
    input  logic                reg_wen,
    input  espm_pkg::word_t     pot_value,
    input  espm_pkg::word_t     misc_word [1:5],
    input  espm_pkg::word_t     crc_good_count,
    input  espm_pkg::word_t     crc_err_count,
    input  espm_pkg::mv_t       mv,
    input  logic                espm_comm_good,
    input  espm_pkg::enc_t      enc_load,
    input  espm_pkg::enc_t      enc_data,
    output espm_pkg::word_t     reg_rdata,
    output logic                espmv_en
);
    import espm_pkg::*;

    word_t rdata_main;
    word_t rdata_board;

    always_comb begin
        case (reg_raddr[3:0])
            OFF_POT_DATA: rdata_main = {20'h0, pot_value[17:6]};
            OFF_ENC_LOAD: rdata_main = {8'h0, enc_load};
            OFF_ENC_DATA: rdata_main = {8'h0, enc_data};
            default:      rdata_main = READ_DEFAULT;
        endcase
    end

    // ------------------------------
    // board-specific space
    // ------------------------------
    always_comb begin
        case (reg_raddr[11:0])
            12'h000: rdata_board = crc_err_count;
            12'h001: rdata_board = crc_good_count;
            12'h002: rdata_board = {16'h0, mv};
            12'h003: rdata_board = {28'h0, misc_word[2][0], misc_word[2][1],
                                    espm_comm_good, espmv_en};  // is_ecm on top
            12'h010: rdata_board = misc_word[2];
            12'h011: rdata_board = misc_word[3];
            12'h012: rdata_board = misc_word[4];
            12'h013: rdata_board = misc_word[5];
            12'h021: rdata_board = misc_word[1];  // switch word
            12'hfff: rdata_board = BUILD_NUMBER;
            default: rdata_board = READ_DEFAULT;
        endcase
    end

    always_comb begin
        case (reg_raddr[15:12])
            ADDR_MAIN:           reg_rdata = rdata_main;
            ADDR_BOARD_SPECIFIC: reg_rdata = rdata_board;
            default:             reg_rdata = READ_DEFAULT;
        endcase
    end

    // espm supply enable, on out of reset
    always_ff @(posedge sysclk) begin
        if (reset) begin
            espmv_en <= 1'b1;
        end else if (reg_wen && (reg_waddr[15:12] == ADDR_BOARD_SPECIFIC)
                     && (reg_waddr[11:0] == 12'h102)) begin
            espmv_en <= reg_wdata[0];
        end
    end

endmodule

`default_nettype wire

/* design/espm_status_top.sv */
`timescale 1ns/1ps
`default_nettype none

module espm_status_top #(
    parameter int              WDOG_WINDOW  = 1024,
    parameter int              MV_NOMINAL   = 36570,
    parameter int              MV_TOLERANCE = 3657,
    parameter espm_pkg::word_t BUILD_NUMBER = 32'h04400000
) (
    input  logic                  sysclk,
    input  logic                  reset,
    input  logic                  rx_word_valid,
    input  espm_pkg::frame_addr_t rx_word_addr,
    input  espm_pkg::word_t       rx_word_data,
    input  logic                  rx_eof,
    input  logic                  rx_crc_good,
    input  logic                  mv_valid,
    input  espm_pkg::mv_t         mv_sample,
    input  espm_pkg::reg_addr_t   reg_waddr,
    input  espm_pkg::word_t       reg_wdata,
    input  logic                  reg_wen,
    input  espm_pkg::reg_addr_t   reg_raddr,
    output espm_pkg::word_t       reg_rdata,
    output logic                  espm_comm_good,
    output logic                  mv_good,
    output logic                  espmv_en
);
    import espm_pkg::*;

    reg_addr_t fld_raddr;
    word_t     pos_value;
    word_t     pot_value;
    word_t     misc_word [1:5];
    word_t     crc_good_count;
    word_t     crc_err_count;
    mv_t       mv;
    enc_t      enc_load;
    enc_t      enc_data;

    frame_copy_if copy_bus ();

    // preload needs the position of the channel being written
    assign fld_raddr = reg_wen ? reg_waddr : reg_raddr;

    espm_frame_buffer frame_buffer (
        .sysclk, .reset, .rx_word_valid, .rx_word_addr, .rx_word_data,
        .rx_crc_good, .copy(copy_bus)
    );

    espm_field_decoder field_decoder (
        .sysclk, .reset, .copy(copy_bus), .fld_raddr,
        .pos_value, .pot_value, .misc_word
    );

    link_health_monitor #(
        .WDOG_WINDOW(WDOG_WINDOW), .MV_NOMINAL(MV_NOMINAL), .MV_TOLERANCE(MV_TOLERANCE)
    ) health (
        .sysclk, .reset, .rx_eof, .rx_crc_good, .copy(copy_bus), .mv_valid,
        .mv_sample, .crc_good_count, .crc_err_count, .mv, .mv_good, .espm_comm_good
    );

    encoder_preload enc_preload (
        .sysclk, .reset, .reg_waddr, .reg_wdata, .reg_wen, .pos_value,
        .reg_raddr, .enc_load, .enc_data
    );

    board_regs #(.BUILD_NUMBER(BUILD_NUMBER)) regs (
        .sysclk, .reset, .reg_raddr, .reg_waddr, .reg_wdata, .reg_wen,
        .pot_value, .misc_word, .crc_good_count, .crc_err_count, .mv,
        .espm_comm_good, .enc_load, .enc_data, .reg_rdata, .espmv_en
    );

endmodule

`default_nettype wire

/* tests/espm_status_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module espm_status_properties (
    input logic                  sysclk,
    input logic                  reset,
    input logic                  valid,
    input espm_pkg::frame_addr_t addr,
    input logic                  frame_done
);
    import espm_pkg::*;

    // ------------------------------
    // copy stream rules
    // ------------------------------
    no_valid_in_reset: assert property (@(posedge sysclk) reset && $past(reset) |-> !valid)
        else $error("copy valid asserted during reset");

    addr_steps: assert property (@(posedge sysclk) disable iff (reset)
        valid && !frame_done |=> valid && (addr == $past(addr) + 1'b1))
        else $error("copy address did not step by one");

    // last word flag only with the final address
    done_at_last: assert property (@(posedge sysclk) disable iff (reset)
        frame_done == (valid && (addr == frame_addr_t'(FRAME_WORDS - 1))))
        else $error("frame_done out of step with address 63");

endmodule

bind espm_frame_buffer espm_status_properties frame_props (
    .sysclk     (sysclk),
    .reset      (reset),
    .valid      (copy.valid),
    .addr       (copy.addr),
    .frame_done (copy.frame_done)
);

`default_nettype wire

/* tests/espm_status_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module espm_status_tb;
    import espm_pkg::*;

    localparam int    WDOG_WINDOW  = 256;
    localparam int    MV_NOMINAL   = 36570;
    localparam int    MV_TOLERANCE = 3657;
    localparam word_t BUILD_NUMBER = 32'h04400000;
    localparam int    CYCLE_LIMIT  = 6000;  // tests need roughly 1.9k cycles

    logic        sysclk = 1'b0;
    logic        reset;
    logic        rx_word_valid;
    frame_addr_t rx_word_addr;
    word_t       rx_word_data;
    logic        rx_eof;
    logic        rx_crc_good;
    logic        mv_valid;
    mv_t         mv_sample;
    reg_addr_t   reg_waddr;
    word_t       reg_wdata;
    logic        reg_wen;
    reg_addr_t   reg_raddr;
    word_t       reg_rdata;
    logic        espm_comm_good;
    logic        mv_good;
    logic        espmv_en;

    // ------------------------------
    // model of the committed state
    // ------------------------------
    word_t model_frame [0:FRAME_WORDS-1];
    enc_t  preload_model [1:7];
    enc_t  pos_at_load [1:7];  // position seen when the preload was written
    word_t exp_good_count;
    word_t exp_err_count;
    mv_t   exp_mv;
    logic  exp_comm_good;
    logic  exp_espmv_en;
    int    cycle_count = 0;

    espm_status_top #(
        .WDOG_WINDOW(WDOG_WINDOW), .MV_NOMINAL(MV_NOMINAL),
        .MV_TOLERANCE(MV_TOLERANCE), .BUILD_NUMBER(BUILD_NUMBER)
    ) dut (.*);

    always #5 sysclk = ~sysclk;

    always @(posedge sysclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic reg_addr_t chan_addr(input logic [2:0] ch, input logic [3:0] off);
        return {ADDR_MAIN, 4'h0, 1'b0, ch, off};
    endfunction

    function automatic bit mv_in_window(input mv_t v);
        return (int'(v) > MV_NOMINAL - MV_TOLERANCE) && (int'(v) < MV_NOMINAL + MV_TOLERANCE);
    endfunction

    // expected read data from the model
    function automatic word_t expected_read(input reg_addr_t addr);
        logic [2:0] ch;
        logic       ok;
        word_t      esii;
        enc_t       enc;
        word_t      result;
        ch     = addr[6:4];
        ok     = !addr[7] && (ch != 3'd0);
        esii   = model_frame[MISC_ADDR_ESII];
        enc    = model_frame[{GROUP_POS, ch}][23:0] - pos_at_load[ch] + preload_model[ch];
        result = READ_DEFAULT;
        if (addr[15:12] == ADDR_MAIN) begin
            case (addr[3:0])
                OFF_POT_DATA: result = ok ? {20'h0, model_frame[{GROUP_POT, ch}][17:6]} : '0;
                OFF_ENC_LOAD: result = ok ? {8'h0, preload_model[ch]} : '0;
                OFF_ENC_DATA: result = ok ? {8'h0, enc} : '0;
                default:      result = READ_DEFAULT;
            endcase
        end else if (addr[15:12] == ADDR_BOARD_SPECIFIC) begin
            case (addr[11:0])
                12'h000: result = exp_err_count;
                12'h001: result = exp_good_count;
                12'h002: result = {16'h0, exp_mv};
                12'h003: result = {28'h0, esii[0], esii[1], exp_comm_good, exp_espmv_en};
                12'h010: result = model_frame[MISC_ADDR_ESII];
                12'h011: result = model_frame[MISC_ADDR_ADC];
                12'h012: result = model_frame[MISC_ADDR_MODEL];
                12'h013: result = model_frame[MISC_ADDR_ID];
                12'h021: result = model_frame[MISC_ADDR_SWITCH];
                12'hfff: result = BUILD_NUMBER;
                default: result = READ_DEFAULT;
            endcase
        end
        return result;
    endfunction

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_flag(input string name, input bit actual, input bit expected);
        if (actual !== expected) begin
            $display("error at %0t: %s is %b, expected %b", $time, name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic read_check(input reg_addr_t addr);
        reg_raddr = addr;
        @(negedge sysclk);
        check_word($sformatf("reg_rdata[%h]", addr), reg_rdata, expected_read(addr));
    endtask

    task automatic send_frame(input bit crc_ok);
        word_t words [0:FRAME_WORDS-1];
        for (int i = 0; i < FRAME_WORDS; i++) begin
            words[i]      = $urandom();
            rx_word_valid = 1'b1;
            rx_word_addr  = frame_addr_t'(i);
            rx_word_data  = words[i];
            @(negedge sysclk);
        end
        rx_word_valid = 1'b0;
        rx_eof        = 1'b1;
        rx_crc_good   = crc_ok;
        @(negedge sysclk);
        rx_eof      = 1'b0;
        rx_crc_good = 1'b0;
        if (crc_ok) begin
            model_frame = words;
            exp_good_count++;
        end else begin
            exp_err_count++;
        end
    endtask

    // eof with good crc and no words, recommits the stored frame
    task automatic commit_stored();
        rx_eof      = 1'b1;
        rx_crc_good = 1'b1;
        @(negedge sysclk);
        rx_eof      = 1'b0;
        rx_crc_good = 1'b0;
        exp_good_count++;
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        @(negedge sysclk);
        reg_wen = 1'b0;
    endtask

    task automatic load_preload(input logic [2:0] ch, input enc_t value);
        write_reg(chan_addr(ch, OFF_ENC_LOAD), {8'h0, value});
        preload_model[ch] = value;
        pos_at_load[ch]   = model_frame[{GROUP_POS, ch}][23:0];
    endtask

    task automatic apply_mv(input mv_t v);
        mv_valid  = 1'b1;
        mv_sample = v;
        @(negedge sysclk);
        mv_valid = 1'b0;
        exp_mv   = v;
        read_check(16'hb002);
        check_flag("mv_good", mv_good, mv_in_window(v));
    endtask

    task automatic check_fields();
        for (int ch = 1; ch <= 7; ch++) begin
            read_check(chan_addr(3'(ch), OFF_POT_DATA));
        end
        for (int i = 0; i < 4; i++) begin
            read_check(16'hb010 + reg_addr_t'(i));
        end
        read_check(16'hb021);
    endtask

    initial begin
        void'($urandom(32'h5651783d));
        reset         = 1'b1;
        rx_word_valid = 1'b0;
        rx_word_addr  = '0;
        rx_word_data  = '0;
        rx_eof        = 1'b0;
        rx_crc_good   = 1'b0;
        mv_valid      = 1'b0;
        mv_sample     = '0;
        reg_waddr     = '0;
        reg_wdata     = '0;
        reg_wen       = 1'b0;
        reg_raddr     = '0;
        for (int i = 0; i < FRAME_WORDS; i++) begin
            model_frame[i] = '0;
        end
        for (int ch = 1; ch <= 7; ch++) begin
            preload_model[ch] = ENC_MIDRANGE;
            pos_at_load[ch]   = '0;
        end
        exp_good_count = '0;
        exp_err_count  = '0;
        exp_mv         = '0;
        exp_comm_good  = 1'b0;
        exp_espmv_en   = 1'b1;
        repeat (8) @(negedge sysclk);
        reset = 1'b0;

        // reset values
        check_flag("espm_comm_good", espm_comm_good, 1'b0);
        check_flag("mv_good", mv_good, 1'b0);
        check_flag("espmv_en", espmv_en, 1'b1);
        read_check(16'hb000);
        read_check(16'hb001);
        for (int ch = 1; ch <= 7; ch++) begin
            read_check(chan_addr(3'(ch), OFF_ENC_LOAD));
        end
        read_check(16'hb0a5);
        read_check(16'h3000);
        read_check(16'hbfff);

        // good frame, status read before the first window end
        send_frame(1'b1);
        repeat (70) @(negedge sysclk);
        read_check(16'hb003);
        check_fields();
        read_check(16'hb001);

        // bad frame leaves the fields alone
        send_frame(1'b0);
        repeat (70) @(negedge sysclk);
        check_fields();
        read_check(16'hb000);
        read_check(16'hb001);

        // ------------------------------
        // encoder preload
        // ------------------------------
        for (int ch = 1; ch <= 7; ch++) begin
            load_preload(3'(ch), enc_t'($urandom()));
        end
        for (int ch = 1; ch <= 7; ch++) begin
            read_check(chan_addr(3'(ch), OFF_ENC_LOAD));
            read_check(chan_addr(3'(ch), OFF_ENC_DATA));
        end
        send_frame(1'b1);
        repeat (70) @(negedge sysclk);
        for (int ch = 1; ch <= 7; ch++) begin
            read_check(chan_addr(3'(ch), OFF_ENC_DATA));
        end
        check_fields();

        // watchdog, one commit every 100 cycles
        repeat (6) begin
            commit_stored();
            repeat (99) @(negedge sysclk);
        end
        exp_comm_good = 1'b1;
        check_flag("espm_comm_good", espm_comm_good, exp_comm_good);
        read_check(16'hb003);
        repeat (600) @(negedge sysclk);
        exp_comm_good = 1'b0;
        check_flag("espm_comm_good", espm_comm_good, exp_comm_good);
        read_check(16'hb001);

        // ------------------------------
        // mv window and supply enable
        // ------------------------------
        apply_mv(mv_t'(MV_NOMINAL));
        apply_mv(mv_t'(MV_NOMINAL - MV_TOLERANCE));
        apply_mv(mv_t'(MV_NOMINAL + MV_TOLERANCE));
        apply_mv(mv_t'(MV_NOMINAL - MV_TOLERANCE + 1));
        apply_mv(mv_t'(MV_NOMINAL + MV_TOLERANCE - 1));
        repeat (8) begin
            apply_mv(mv_t'($urandom_range(MV_NOMINAL + 2 * MV_TOLERANCE,
                                          MV_NOMINAL - 2 * MV_TOLERANCE)));
        end
        write_reg(16'hb102, 32'h0);
        exp_espmv_en = 1'b0;
        check_flag("espmv_en", espmv_en, exp_espmv_en);
        read_check(16'hb003);

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
design/espm_pkg.sv
design/frame_copy_if.sv
design/espm_frame_buffer.sv
design/espm_field_decoder.sv
design/link_health_monitor.sv
design/encoder_preload.sv
design/board_regs.sv
design/espm_status_top.sv
tests/espm_status_properties.sv
tests/espm_status_tb.sv

/* run.sh */
#!/bin/sh
# build and run the espm status testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module espm_status_tb -f sources.f -o sim_espm
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_espm
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
fi
exit "$status"
